//--- all.f
+incdir+tb
logic/exec_pkg.sv
logic/isn_decode.sv
logic/word_alu.sv
logic/branch_unit.sv
logic/ash_shifter.sv
logic/result_writeback.sv
logic/execute_top.sv
tb/tb_execute.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_execute -o sim_execute
out=$(./obj_dir/sim_execute)
echo "$out"
echo "$out" | grep -qF "*** TEST PASSED ***"

//--- tb/exec_model.svh
// ~~~~~~~~~~~~~~~~~~~~
// reference model of the execute stage
// included by the testbench, computes expected result, flags and pc
// ~~~~~~~~~~~~~~~~~~~~
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// word ops, returns {result, n z v c}
function automatic logic [19:0] expect_word(input logic [15:0] isn, input logic [15:0] ss,
                                            input logic [15:0] dd, input logic [3:0] cci);
   logic [15:0] r;
   logic [16:0] u;
   logic [16:0] s;
   logic [3:0]  cc;
   logic        n;
   logic        z;
   logic        v;
   logic        c;
   logic        rot;
   r   = 16'd0;
   u   = 17'd0;
   s   = 17'd0;
   v   = 1'b0;
   c   = cci[0];
   rot = 1'b0;
   case (isn[15:12])
      4'o01: r = ss;
      4'o02:
      begin
         u = {1'b0, ss} - {1'b0, dd};
         s = {ss[15], ss} - {dd[15], dd};
         r = u[15:0];
         c = u[16];
         v = s[16] ^ s[15];
      end
      4'o03: r = ss & dd;
      4'o04: r = dd & ~ss;
      4'o05: r = ss | dd;
      4'o06:
      begin
         u = {1'b0, ss} + {1'b0, dd};
         s = {ss[15], ss} + {dd[15], dd};
         r = u[15:0];
         c = u[16];
         v = s[16] ^ s[15];
      end
      4'o16:
      begin
         u = {1'b0, dd} - {1'b0, ss};
         s = {dd[15], dd} - {ss[15], ss};
         r = u[15:0];
         c = u[16];
         v = s[16] ^ s[15];
      end
      4'o00:
      begin
         case (isn[11:6])
            6'o03:
            begin
               r = {dd[7:0], dd[15:8]};
               c = 1'b0;
            end
            6'o50: c = 1'b0;
            6'o51:
            begin
               r = ~dd;
               c = 1'b1;
            end
            6'o52:
            begin
               s = {dd[15], dd} + 17'd1;
               r = s[15:0];
               v = s[16] ^ s[15];
            end
            6'o53:
            begin
               s = {dd[15], dd} - 17'd1;
               r = s[15:0];
               v = s[16] ^ s[15];
            end
            6'o54:
            begin
               r = 16'd0 - dd;
               v = (dd == 16'h8000);
               c = (dd != 16'd0);
            end
            6'o55, 6'o56:
            begin
               if (isn[11:6] == 6'o56)
               begin
                  u = {1'b0, dd} - {16'd0, cci[0]};
                  s = {dd[15], dd} - {16'd0, cci[0]};
               end
               else
               begin
                  u = {1'b0, dd} + {16'd0, cci[0]};
                  s = {dd[15], dd} + {16'd0, cci[0]};
               end
               r = u[15:0];
               c = u[16];
               v = s[16] ^ s[15];
            end
            6'o57:
            begin
               r = dd;
               c = 1'b0;
            end
            6'o60:
            begin
               r = {cci[0], dd[15:1]};
               c = dd[0];
            end
            6'o61:
            begin
               r = {dd[14:0], cci[0]};
               c = dd[15];
            end
            6'o62:
            begin
               r = {dd[15], dd[15:1]};
               c = dd[0];
            end
            6'o63:
            begin
               r = {dd[14:0], 1'b0};
               c = dd[15];
            end
            default: r = 16'd0;
         endcase
         rot = (isn[11:6] >= 6'o60) && (isn[11:6] <= 6'o63);
      end
      default: r = 16'd0;
   endcase
   n = r[15];
   z = (r == 16'd0);
   if (isn[15:6] == 10'o0003)
   begin
      n = r[7];
      z = (r[7:0] == 8'd0);
   end
   if (rot)
      v = n ^ c;
   cc = {n, z, v, c};
   // set or clear the named flags
   if (isn[15:5] == 11'o0005)
      cc = isn[4] ? (cci | isn[3:0]) : (cci & ~isn[3:0]);
   return {r, cc};
endfunction

// ash of val by a signed 6 bit count, returns {result, n z v c}
function automatic logic [19:0] expect_ash(input logic [15:0] val, input logic [5:0] cnt);
   logic [15:0] r;
   logic        v;
   logic        c;
   int          k;
   r = val;
   v = 1'b0;
   c = 1'b0;
   k = cnt[5] ? (64 - int'(cnt)) : int'(cnt);
   for (int i = 0; i < k; i++)
   begin
      if (!cnt[5])
      begin
         c = r[15];
         r = {r[14:0], 1'b0};
         if (r[15] != c)
            v = 1'b1;
      end
      else
      begin
         c = r[0];
         r = {r[15], r[15:1]};
      end
   end
   return {r, r[15], (r == 16'd0), v, c};
endfunction

function automatic logic expect_taken(input logic [3:0] cond, input logic [3:0] cc);
   logic n;
   logic z;
   logic v;
   logic c;
   {n, z, v, c} = cc;
   case (cond)
      4'h1: return 1'b1;
      4'h2: return !z;
      4'h3: return z;
      4'h4: return n == v;
      4'h5: return n != v;
      4'h6: return !z && (n == v);
      4'h7: return z || (n != v);
      4'h8: return !n;
      4'h9: return n;
      4'ha: return !c && !z;
      4'hb: return c || z;
      4'hc: return !v;
      4'hd: return v;
      4'he: return !c;
      default: return c;
   endcase
endfunction

function automatic logic [15:0] expect_target(input logic [15:0] pc_v, input logic [7:0] off);
   logic [15:0] ext;
   ext = {{8{off[7]}}, off};
   return pc_v + ext + ext;
endfunction

`endif

//--- tb/tb_execute.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the execute stage
// strobes instructions, checks each result against the model in issue order
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_execute;

   `include "exec_model.svh"

   localparam int reset_cycles = 10;
   localparam int planned      = 160;

   logic        clk;
   logic        arst_n;
   logic        isn_valid;
   logic [15:0] isn;
   logic [15:0] pc;
   logic [15:0] ss_data;
   logic [15:0] dd_data;
   logic [3:0]  cc_in;
   logic        result_valid;
   logic [15:0] result;
   logic [3:0]  cc_out;
   logic        latch_cc;
   logic [15:0] new_pc;
   logic        latch_pc;
   logic        busy;

   int          cyc;
   int          errors;
   int          tests;
   int          failed_tests;
   logic [31:0] rng;

   // expected items, in issue order
   string       q_name[$];
   logic [15:0] q_res[$];
   logic [3:0]  q_cc[$];
   logic        q_lcc[$];
   logic [15:0] q_pc[$];
   logic        q_lpc[$];
   int          q_cyc[$];

   execute_top dut
   (
      .clk(clk), .arst_n(arst_n), .isn_valid(isn_valid), .isn(isn), .pc(pc),
      .ss_data(ss_data), .dd_data(dd_data), .cc_in(cc_in),
      .result_valid(result_valid), .result(result), .cc_out(cc_out),
      .latch_cc(latch_cc), .new_pc(new_pc), .latch_pc(latch_pc), .busy(busy)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
      cyc <= cyc + 1;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_rand(output logic [15:0] val);
      rng = xorshift(rng);
      val = rng[15:0];
   endtask

   task automatic report_mismatch(input string name, input string what,
                                  input logic [15:0] exp_v, input logic [15:0] act_v);
      $display("FAIL %s %s expected %h actual %h", name, what, exp_v, act_v);
      errors++;
   endtask

   // strobe one instruction on the falling edge and queue its expectation
   task automatic send(input string name, input logic [15:0] i_w, input logic [15:0] p_w,
                       input logic [15:0] s_w, input logic [15:0] d_w, input logic [3:0] c_w,
                       input int lat, input logic [15:0] e_res, input logic [3:0] e_cc,
                       input logic e_lcc, input logic [15:0] e_pc, input logic e_lpc);
      @(negedge clk);
      isn_valid = 1'b1;
      isn       = i_w;
      pc        = p_w;
      ss_data   = s_w;
      dd_data   = d_w;
      cc_in     = c_w;
      q_name.push_back(name);
      q_res.push_back(e_res);
      q_cc.push_back(e_cc);
      q_lcc.push_back(e_lcc);
      q_pc.push_back(e_pc);
      q_lpc.push_back(e_lpc);
      q_cyc.push_back(cyc + lat);
   endtask

   task automatic drain();
      @(negedge clk);
      isn_valid = 1'b0;
      while (q_res.size() != 0)
         @(negedge clk);
   endtask

   task automatic close_test(input string name, input int err_start);
      tests++;
      if (errors != err_start)
         failed_tests++;
      $display("test %s: %0d errors", name, errors - err_start);
   endtask

   // outputs are stable on the falling edge
   always @(negedge clk)
   begin
      if (arst_n && result_valid)
      begin
         if (q_res.size() == 0)
         begin
            $display("FAIL result_valid came with no instruction pending, cycle %0d", cyc);
            errors++;
         end
         else
         begin
            assert (cyc == q_cyc[0])
            else report_mismatch(q_name[0], "cycle", q_cyc[0][15:0], cyc[15:0]);
            assert (result == q_res[0])
            else report_mismatch(q_name[0], "result", q_res[0], result);
            assert (cc_out == q_cc[0])
            else report_mismatch(q_name[0], "cc_out", {12'd0, q_cc[0]}, {12'd0, cc_out});
            assert (latch_cc == q_lcc[0])
            else report_mismatch(q_name[0], "latch_cc", {15'd0, q_lcc[0]}, {15'd0, latch_cc});
            assert (new_pc == q_pc[0])
            else report_mismatch(q_name[0], "new_pc", q_pc[0], new_pc);
            assert (latch_pc == q_lpc[0])
            else report_mismatch(q_name[0], "latch_pc", {15'd0, q_lpc[0]}, {15'd0, latch_pc});
            void'(q_name.pop_front());
            void'(q_res.pop_front());
            void'(q_cc.pop_front());
            void'(q_lcc.pop_front());
            void'(q_pc.pop_front());
            void'(q_lpc.pop_front());
            void'(q_cyc.pop_front());
         end
      end
   end

   initial
   begin
      #((reset_cycles + planned * 70) * 20);
      $display("timeout, results still missing after %0d cycles", cyc);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] r;
      logic [15:0] w;
      logic [19:0] e;
      logic [3:0]  cond;
      logic [5:0]  cnt;
      logic [5:0]  mag;
      logic [3:0]  dops[7];
      logic [5:0]  sops[15];
      logic [5:0]  counts[12];
      int          err0;
      dops   = '{4'o01, 4'o02, 4'o03, 4'o04, 4'o05, 4'o06, 4'o16};
      sops   = '{6'o03, 6'o50, 6'o51, 6'o52, 6'o53, 6'o54, 6'o55, 6'o56,
                 6'o57, 6'o60, 6'o61, 6'o62, 6'o63, 6'o02, 6'o02};
      counts = '{6'd0, 6'd1, 6'd5, 6'd15, 6'd17, 6'd31, 6'h3f, 6'h3c, 6'h30, 6'h20,
                 6'h31, 6'd2};
      clk = 1'b0;
      arst_n = 1'b0;
      isn_valid = 1'b0;
      isn = 16'd0;
      pc = 16'd0;
      ss_data = 16'd0;
      dd_data = 16'd0;
      cc_in = 4'd0;
      cyc = 0;
      errors = 0;
      tests = 0;
      failed_tests = 0;
      rng = 32'h12cd;
      repeat (reset_cycles) @(negedge clk);
      arst_n = 1'b1;

      err0 = errors;
      repeat (20)
      begin
         @(negedge clk);
         assert (!result_valid && !latch_cc && !latch_pc && !busy)
         else
         begin
            $display("FAIL reset_idle an output went high with no stimulus");
            errors++;
         end
      end
      close_test("reset_idle", err0);

      err0 = errors;
      for (int i = 0; i < 40; i++)
      begin
         next_rand(a);
         next_rand(b);
         next_rand(r);
         next_rand(w);
         w = {dops[r[15:8] % 7], w[11:0]};
         e = expect_word(w, a, b, r[3:0]);
         send("double_op", w, 16'd0, a, b, r[3:0], 2, e[19:4], e[3:0], 1'b1, 16'd0, 1'b0);
      end
      drain();
      close_test("double_op", err0);

      err0 = errors;
      for (int i = 0; i < 45; i++)
      begin
         next_rand(a);
         next_rand(b);
         next_rand(r);
         w = {4'o00, sops[i % 15], r[13:8]};
         // cc set and clear ops sit at 000240 to 000277
         if (sops[i % 15] == 6'o02)
            w = {11'o0005, r[12:8]};
         e = expect_word(w, a, b, r[3:0]);
         send("single_op", w, 16'd0, a, b, r[3:0], 2, e[19:4], e[3:0], 1'b1, 16'd0, 1'b0);
      end
      drain();
      close_test("single_op", err0);

      err0 = errors;
      for (int i = 0; i < 45; i++)
      begin
         next_rand(a);
         next_rand(r);
         cond = 4'd1 + 4'(i % 15);
         w = {cond[3], 4'b0000, cond[2:0], r[15:8]};
         send("branch", w, a, 16'd0, 16'd0, r[3:0], 2, 16'd0, 4'd0, 1'b0,
              expect_target(a, r[15:8]), expect_taken(cond, r[3:0]));
      end
      drain();
      close_test("branch", err0);

      err0 = errors;
      for (int i = 0; i < 12; i++)
      begin
         next_rand(a);
         next_rand(b);
         cnt = counts[i];
         mag = cnt[5] ? (6'd0 - cnt) : cnt;
         e = expect_ash(a, cnt);
         send("ash", 16'o072000 | {10'd0, b[5:0]}, 16'd0, a, {b[15:6], cnt}, 4'd0,
              2 + int'(mag), e[19:4], e[3:0], 1'b1, 16'd0, 1'b0);
         drain();
      end
      // a strobe while busy must vanish
      e = expect_ash(16'h1234, 6'd3);
      send("ash_busy", 16'o072000, 16'd0, 16'h1234, 16'd3, 4'd0, 5, e[19:4], e[3:0],
           1'b1, 16'd0, 1'b0);
      @(negedge clk);
      assert (busy)
      else
      begin
         $display("FAIL ash_busy busy was low right after an ash strobe");
         errors++;
      end
      isn = 16'o060102;
      ss_data = 16'd1;
      dd_data = 16'd2;
      drain();
      repeat (5) @(negedge clk);
      close_test("ash", err0);

      err0 = errors;
      send("unimplemented", 16'o000000, 16'h0100, 16'h5555, 16'haaaa, 4'hf, 2, 16'd0, 4'd0,
           1'b0, 16'd0, 1'b0);
      drain();
      close_test("unimplemented", err0);

      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- logic/execute_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// PDP-11 execute stage, word ops, branches and ash
// strobe in with isn_valid, results come back on result_valid
// the source must hold off while busy is high
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module execute_top
(
   input  logic            clk,
   input  logic            arst_n,
   input  logic            isn_valid,
   input  exec_pkg::word_t isn,
   input  exec_pkg::word_t pc,
   input  exec_pkg::word_t ss_data,
   input  exec_pkg::word_t dd_data,
   input  exec_pkg::cc_t   cc_in,
   output logic            result_valid,
   output exec_pkg::word_t result,
   output exec_pkg::cc_t   cc_out,
   output logic            latch_cc,
   output exec_pkg::word_t new_pc,
   output logic            latch_pc,
   output logic            busy
);

   logic                   op_valid;
   exec_pkg::op_class_e    op_class;
   exec_pkg::alu_op_e      alu_op;
   exec_pkg::branch_cond_e branch_cond;
   exec_pkg::word_t        src;
   exec_pkg::word_t        dst;
   exec_pkg::word_t        pc_q;
   exec_pkg::cc_t          cc_q;
   logic [4:0]             ccop_bits;
   logic [7:0]             offset;
   logic                   ash_start;
   logic [5:0]             ash_count;
   exec_pkg::word_t        alu_result;
   exec_pkg::cc_t          alu_cc;
   logic                   alu_latch_cc;
   exec_pkg::word_t        br_pc;
   logic                   br_take;
   logic                   ash_done;
   exec_pkg::word_t        ash_result;
   exec_pkg::cc_t          ash_cc;

   isn_decode u_decode
   (
      .clk(clk), .arst_n(arst_n),
      .isn_valid(isn_valid), .isn(isn), .pc(pc),
      .ss_data(ss_data), .dd_data(dd_data), .cc_in(cc_in), .busy(busy),
      .op_valid(op_valid), .op_class(op_class), .alu_op(alu_op),
      .branch_cond(branch_cond), .src(src), .dst(dst), .pc_q(pc_q),
      .cc_q(cc_q), .ccop_bits(ccop_bits), .offset(offset),
      .ash_start(ash_start), .ash_count(ash_count)
   );

   word_alu u_alu
   (
      .alu_op(alu_op), .op_class(op_class), .src(src), .dst(dst),
      .cc_q(cc_q), .ccop_bits(ccop_bits),
      .alu_result(alu_result), .alu_cc(alu_cc), .alu_latch_cc(alu_latch_cc)
   );

   branch_unit u_branch
   (
      .branch_cond(branch_cond), .pc_q(pc_q), .cc_q(cc_q), .offset(offset),
      .br_pc(br_pc), .br_take(br_take)
   );

   ash_shifter u_ash
   (
      .clk(clk), .arst_n(arst_n),
      .ash_start(ash_start), .ash_count(ash_count), .src(src),
      .busy(busy), .ash_done(ash_done), .ash_result(ash_result), .ash_cc(ash_cc)
   );

   result_writeback u_writeback
   (
      .clk(clk), .arst_n(arst_n),
      .op_valid(op_valid), .op_class(op_class),
      .alu_result(alu_result), .alu_cc(alu_cc), .alu_latch_cc(alu_latch_cc),
      .br_pc(br_pc), .br_take(br_take),
      .ash_done(ash_done), .ash_result(ash_result), .ash_cc(ash_cc),
      .result_valid(result_valid), .result(result), .cc_out(cc_out),
      .latch_cc(latch_cc), .new_pc(new_pc), .latch_pc(latch_pc)
   );

endmodule

//--- logic/result_writeback.sv
// ~~~~~~~~~~~~~~~~~~~~
// output side, registers the finished result of one unit
// ash results are taken on ash_done, all others one cycle after decode
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module result_writeback
(
   input  logic                clk,
   input  logic                arst_n,
   input  logic                op_valid,
   input  exec_pkg::op_class_e op_class,
   input  exec_pkg::word_t     alu_result,
   input  exec_pkg::cc_t       alu_cc,
   input  logic                alu_latch_cc,
   input  exec_pkg::word_t     br_pc,
   input  logic                br_take,
   input  logic                ash_done,
   input  exec_pkg::word_t     ash_result,
   input  exec_pkg::cc_t       ash_cc,
   output logic                result_valid,
   output exec_pkg::word_t     result,
   output exec_pkg::cc_t       cc_out,
   output logic                latch_cc,
   output exec_pkg::word_t     new_pc,
   output logic                latch_pc
);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         result_valid <= 1'b0;
         latch_cc     <= 1'b0;
         latch_pc     <= 1'b0;
      end
      else
      begin
         // nop instructions still report, idle cycles do not
         result_valid <= ash_done | (op_valid & (op_class != exec_pkg::cls_ash));
         latch_cc     <= ash_done | ((op_class == exec_pkg::cls_alu) & alu_latch_cc);
         latch_pc     <= (op_class == exec_pkg::cls_branch) & br_take;
      end
   end

   always_ff @(posedge clk)
   begin
      result <= 16'd0;
      cc_out <= 4'd0;
      new_pc <= 16'd0;
      if (ash_done)
      begin
         result <= ash_result;
         cc_out <= ash_cc;
      end
      else if (op_class == exec_pkg::cls_alu)
      begin
         result <= alu_result;
         cc_out <= alu_cc;
      end
      // target is reported even when the branch falls through
      else if (op_class == exec_pkg::cls_branch)
         new_pc <= br_pc;
   end

endmodule

//--- logic/ash_shifter.sv
// ~~~~~~~~~~~~~~~~~~~~
// multi-cycle arithmetic shift for ash, one bit per clock
// positive count shifts left, negative count shifts right
// a zero count finishes in the start cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ash_shifter
(
   input  logic            clk,
   input  logic            arst_n,
   input  logic            ash_start,
   input  logic [5:0]      ash_count,
   input  exec_pkg::word_t src,
   output logic            busy,
   output logic            ash_done,
   output exec_pkg::word_t ash_result,
   output exec_pkg::cc_t   ash_cc
);

   typedef enum logic {st_idle, st_shift} state_e;

   state_e          state;
   logic [5:0]      remain_q;
   logic [5:0]      mag;
   logic            load;
   logic            step_en;
   logic            shl;
   logic            left_q;
   exec_pkg::word_t word_q;
   exec_pkg::word_t step_in;
   exec_pkg::word_t step_out;
   logic            out_bit;
   logic            c_q;
   logic            v_q;

   // magnitude of a two's complement count, -32 gives 32
   assign mag  = ash_count[5] ? (6'd0 - ash_count) : ash_count;
   assign load = ash_start && (mag != 6'd0);

   // the first step is taken while loading
   assign step_en  = (state == st_idle) ? load : (remain_q != 6'd0);
   assign shl      = (state == st_idle) ? ~ash_count[5] : left_q;
   assign step_in  = (state == st_idle) ? src : word_q;
   assign step_out = shl ? {step_in[14:0], 1'b0} : {step_in[15], step_in[15:1]};
   assign out_bit  = shl ? step_in[15] : step_in[0];

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= st_idle;
         remain_q <= 6'd0;
      end
      else if (state == st_idle)
      begin
         if (load)
         begin
            state    <= st_shift;
            remain_q <= mag - 6'd1;
         end
      end
      else if (remain_q == 6'd0)
         state <= st_idle;
      else
         remain_q <= remain_q - 6'd1;
   end

   always_ff @(posedge clk)
   begin
      if (step_en)
      begin
         word_q <= step_out;
         c_q    <= out_bit;
         // v sticks once the sign bit has changed
         v_q    <= ((state == st_shift) & v_q) | (step_out[15] ^ step_in[15]);
      end
      if (load)
         left_q <= ~ash_count[5];
   end

   assign busy     = ash_start | (state == st_shift);
   assign ash_done = (ash_start && mag == 6'd0) || (state == st_shift && remain_q == 6'd0);

   assign ash_result = (state == st_shift) ? word_q : src;
   assign ash_cc     = {ash_result[15], ash_result == 16'd0,
                        (state == st_shift) & v_q, (state == st_shift) & c_q};

endmodule

//--- logic/branch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// conditional branch target and taken test
// combinational, from the registered pc, cc and offset
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module branch_unit
(
   input  exec_pkg::branch_cond_e branch_cond,
   input  exec_pkg::word_t        pc_q,
   input  exec_pkg::cc_t          cc_q,
   input  logic [7:0]             offset,
   output exec_pkg::word_t        br_pc,
   output logic                   br_take
);

   logic cc_n;
   logic cc_z;
   logic cc_v;
   logic cc_c;

   assign {cc_n, cc_z, cc_v, cc_c} = cc_q;

   // word offset, so twice the sign extended byte
   assign br_pc = pc_q + {{7{offset[7]}}, offset, 1'b0};

   always_comb
   begin
      case (branch_cond)
         exec_pkg::br:   br_take = 1'b1;
         exec_pkg::bne:  br_take = ~cc_z;
         exec_pkg::beq:  br_take = cc_z;
         exec_pkg::bge:  br_take = ~(cc_n ^ cc_v);
         exec_pkg::blt:  br_take = cc_n ^ cc_v;
         exec_pkg::bgt:  br_take = ~(cc_z | (cc_n ^ cc_v));
         exec_pkg::ble:  br_take = cc_z | (cc_n ^ cc_v);
         exec_pkg::bpl:  br_take = ~cc_n;
         exec_pkg::bmi:  br_take = cc_n;
         exec_pkg::bhi:  br_take = ~(cc_c | cc_z);
         exec_pkg::blos: br_take = cc_c | cc_z;
         exec_pkg::bvc:  br_take = ~cc_v;
         exec_pkg::bvs:  br_take = cc_v;
         exec_pkg::bcc:  br_take = ~cc_c;
         exec_pkg::bcs:  br_take = cc_c;
         default:        br_take = 1'b0;
      endcase
   end

endmodule

//--- logic/word_alu.sv
// ~~~~~~~~~~~~~~~~~~~~
// word arithmetic, logic, rotate, swab and cc ops
// purely combinational, fed by the registered decode fields
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module word_alu
(
   input  exec_pkg::alu_op_e   alu_op,
   input  exec_pkg::op_class_e op_class,
   input  exec_pkg::word_t     src,
   input  exec_pkg::word_t     dst,
   input  exec_pkg::cc_t       cc_q,
   input  logic [4:0]          ccop_bits,
   output exec_pkg::word_t     alu_result,
   output exec_pkg::cc_t       alu_cc,
   output logic                alu_latch_cc
);

   exec_pkg::word_t res;
   logic [16:0]     sum;
   logic            c_in;
   logic            n_f;
   logic            z_f;
   logic            v_f;
   logic            c_f;

   assign c_in = cc_q[0];

   always_comb
   begin
      res = 16'd0;
      sum = 17'd0;
      v_f = 1'b0;
      c_f = c_in;
      case (alu_op)
         exec_pkg::alu_mov: res = src;
         exec_pkg::alu_bit: res = src & dst;
         exec_pkg::alu_bic: res = ~src & dst;
         exec_pkg::alu_bis: res = src | dst;
         exec_pkg::alu_cmp:
         begin
            // src minus dst, c is the borrow
            sum = {1'b0, src} - {1'b0, dst};
            res = sum[15:0];
            c_f = sum[16];
            v_f = (src[15] ^ dst[15]) & (res[15] ^ src[15]);
         end
         exec_pkg::alu_add:
         begin
            sum = {1'b0, src} + {1'b0, dst};
            res = sum[15:0];
            c_f = sum[16];
            v_f = ~(src[15] ^ dst[15]) & (res[15] ^ src[15]);
         end
         exec_pkg::alu_sub:
         begin
            // dst minus src, the other way round from cmp
            sum = {1'b0, dst} - {1'b0, src};
            res = sum[15:0];
            c_f = sum[16];
            v_f = (src[15] ^ dst[15]) & (res[15] ^ dst[15]);
         end
         exec_pkg::alu_clr: c_f = 1'b0;
         exec_pkg::alu_com:
         begin
            res = ~dst;
            c_f = 1'b1;
         end
         exec_pkg::alu_inc:
         begin
            res = dst + 16'd1;
            v_f = (res == 16'o100000);
         end
         exec_pkg::alu_dec:
         begin
            res = dst - 16'd1;
            v_f = (res == 16'o077777);
         end
         exec_pkg::alu_neg:
         begin
            res = 16'd0 - dst;
            v_f = (res == 16'o100000);
            c_f = (res != 16'd0);
         end
         exec_pkg::alu_adc:
         begin
            res = dst + {15'd0, c_in};
            v_f = c_in & (res == 16'o100000);
            c_f = c_in & (res == 16'd0);
         end
         exec_pkg::alu_sbc:
         begin
            res = dst - {15'd0, c_in};
            v_f = c_in & (res == 16'o077777);
            c_f = c_in & (res == 16'o177777);
         end
         exec_pkg::alu_tst:
         begin
            res = dst;
            c_f = 1'b0;
         end
         exec_pkg::alu_ror:
         begin
            res = {c_in, dst[15:1]};
            c_f = dst[0];
         end
         exec_pkg::alu_rol:
         begin
            res = {dst[14:0], c_in};
            c_f = dst[15];
         end
         exec_pkg::alu_asr:
         begin
            res = {dst[15], dst[15:1]};
            c_f = dst[0];
         end
         exec_pkg::alu_asl:
         begin
            res = {dst[14:0], 1'b0};
            c_f = dst[15];
         end
         exec_pkg::alu_swab:
         begin
            res = {dst[7:0], dst[15:8]};
            c_f = 1'b0;
         end
         // cc ops carry no word result
         default: res = 16'd0;
      endcase

      n_f = res[15];
      z_f = (res == 16'd0);
      // swab flags look at the new low byte
      if (alu_op == exec_pkg::alu_swab)
      begin
         n_f = res[7];
         z_f = (res[7:0] == 8'd0);
      end
      if (alu_op inside {exec_pkg::alu_ror, exec_pkg::alu_rol,
                         exec_pkg::alu_asr, exec_pkg::alu_asl})
         v_f = n_f ^ c_f;

      alu_cc = {n_f, z_f, v_f, c_f};
      // bit 4 picks set over clear, bits 3:0 name n z v c
      if (alu_op == exec_pkg::alu_ccop)
         alu_cc = ccop_bits[4] ? (cc_q | ccop_bits[3:0]) : (cc_q & ~ccop_bits[3:0]);
   end

   assign alu_result   = res;
   assign alu_latch_cc = (op_class == exec_pkg::cls_alu);

endmodule

//--- logic/isn_decode.sv
// ~~~~~~~~~~~~~~~~~~~~
// input side of the execute stage
// samples a strobed instruction with its operands and classifies it
// strobes are dropped while busy is high
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module isn_decode
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   isn_valid,
   input  exec_pkg::word_t        isn,
   input  exec_pkg::word_t        pc,
   input  exec_pkg::word_t        ss_data,
   input  exec_pkg::word_t        dd_data,
   input  exec_pkg::cc_t          cc_in,
   input  logic                   busy,
   output logic                   op_valid,
   output exec_pkg::op_class_e    op_class,
   output exec_pkg::alu_op_e      alu_op,
   output exec_pkg::branch_cond_e branch_cond,
   output exec_pkg::word_t        src,
   output exec_pkg::word_t        dst,
   output exec_pkg::word_t        pc_q,
   output exec_pkg::cc_t          cc_q,
   output logic [4:0]             ccop_bits,
   output logic [7:0]             offset,
   output logic                   ash_start,
   output logic [5:0]             ash_count
);

   // isn[15:12] of the double operand group
   localparam logic [3:0] dop_single = 4'o00;
   localparam logic [3:0] dop_mov    = 4'o01;
   localparam logic [3:0] dop_cmp    = 4'o02;
   localparam logic [3:0] dop_bit    = 4'o03;
   localparam logic [3:0] dop_bic    = 4'o04;
   localparam logic [3:0] dop_bis    = 4'o05;
   localparam logic [3:0] dop_add    = 4'o06;
   localparam logic [3:0] dop_eis    = 4'o07;
   localparam logic [3:0] dop_sub    = 4'o16;

   // isn[11:9] of ash inside the eis group
   localparam logic [2:0] eis_ash    = 3'o2;

   // isn[11:6] of the 0000xx group
   localparam logic [5:0] sop_ccop   = 6'o02;
   localparam logic [5:0] sop_swab   = 6'o03;

   logic                   accept;
   exec_pkg::op_class_e    cls_d;
   exec_pkg::alu_op_e      alu_d;
   exec_pkg::branch_cond_e cond_d;

   assign accept = isn_valid & ~busy;

   always_comb
   begin
      cls_d  = exec_pkg::cls_alu;
      alu_d  = exec_pkg::alu_mov;
      cond_d = exec_pkg::br;
      // branches sit at 0004xx-0037xx and 1000xx-1037xx
      if (isn[14:11] == 4'b0000 && {isn[15], isn[10:8]} != 4'h0)
      begin
         cls_d  = exec_pkg::cls_branch;
         cond_d = exec_pkg::branch_cond_e'({isn[15], isn[10:8]});
      end
      else
      begin
         case (isn[15:12])
            dop_mov: alu_d = exec_pkg::alu_mov;
            dop_cmp: alu_d = exec_pkg::alu_cmp;
            dop_bit: alu_d = exec_pkg::alu_bit;
            dop_bic: alu_d = exec_pkg::alu_bic;
            dop_bis: alu_d = exec_pkg::alu_bis;
            dop_add: alu_d = exec_pkg::alu_add;
            dop_sub: alu_d = exec_pkg::alu_sub;
            dop_eis: cls_d = (isn[11:9] == eis_ash) ? exec_pkg::cls_ash : exec_pkg::cls_nop;
            dop_single:
            begin
               case (isn[11:6])
                  sop_ccop: alu_d = exec_pkg::alu_ccop;
                  sop_swab: alu_d = exec_pkg::alu_swab;
                  6'o50:    alu_d = exec_pkg::alu_clr;
                  6'o51:    alu_d = exec_pkg::alu_com;
                  6'o52:    alu_d = exec_pkg::alu_inc;
                  6'o53:    alu_d = exec_pkg::alu_dec;
                  6'o54:    alu_d = exec_pkg::alu_neg;
                  6'o55:    alu_d = exec_pkg::alu_adc;
                  6'o56:    alu_d = exec_pkg::alu_sbc;
                  6'o57:    alu_d = exec_pkg::alu_tst;
                  6'o60:    alu_d = exec_pkg::alu_ror;
                  6'o61:    alu_d = exec_pkg::alu_rol;
                  6'o62:    alu_d = exec_pkg::alu_asr;
                  6'o63:    alu_d = exec_pkg::alu_asl;
                  default:  cls_d = exec_pkg::cls_nop;
               endcase
               // only 00024x-00027x are cc ops, rts and spl live below
               if (isn[11:6] == sop_ccop && !isn[5])
                  cls_d = exec_pkg::cls_nop;
            end
            // byte ops, mul, div and friends
            default: cls_d = exec_pkg::cls_nop;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         op_valid  <= 1'b0;
         op_class  <= exec_pkg::cls_nop;
         ash_start <= 1'b0;
      end
      else
      begin
         op_valid  <= accept;
         op_class  <= accept ? cls_d : exec_pkg::cls_nop;
         ash_start <= accept && (cls_d == exec_pkg::cls_ash);
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         alu_op      <= alu_d;
         branch_cond <= cond_d;
         src         <= ss_data;
         dst         <= dd_data;
         pc_q        <= pc;
         cc_q        <= cc_in;
         ccop_bits   <= isn[4:0];
         offset      <= isn[7:0];
         // shift count is the low six bits of the source operand
         ash_count   <= dd_data[5:0];
      end
   end

endmodule

//--- logic/exec_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared types for the PDP-11 execute stage
// every module refers to them as exec_pkg::name
// ~~~~~~~~~~~~~~~~~~~~
package exec_pkg;

   // data word, pc or instruction
   typedef logic [15:0] word_t;

   // condition codes n z v c, high to low
   typedef logic [3:0] cc_t;

   // unit that produces the result
   typedef enum logic [1:0] {
      cls_nop,
      cls_alu,
      cls_branch,
      cls_ash
   } op_class_e;

   typedef enum logic [4:0] {
      alu_mov, alu_cmp, alu_bit, alu_bic, alu_bis, alu_add, alu_sub,
      alu_clr, alu_com, alu_inc, alu_dec, alu_neg, alu_adc, alu_sbc, alu_tst,
      alu_ror, alu_rol, alu_asr, alu_asl, alu_swab,
      alu_ccop
   } alu_op_e;

   // encoded as {isn[15], isn[10:8]} of the branch word
   typedef enum logic [3:0] {
      br = 4'h1, bne = 4'h2, beq = 4'h3, bge = 4'h4,
      blt = 4'h5, bgt = 4'h6, ble = 4'h7, bpl = 4'h8,
      bmi = 4'h9, bhi = 4'ha, blos = 4'hb, bvc = 4'hc,
      bvs = 4'hd, bcc = 4'he, bcs = 4'hf
   } branch_cond_e;

endpackage
